// ==== pll_reconfig_ctrl.f ====
source/pll_reconfig_pkg.sv
source/pll_user_regs.sv
source/pll_l2p_map.sv
source/pll_rmw_datapath.sv
source/pll_rmw_sequencer.sv
source/pll_reconfig_ctrl.sv
sim/basic_block_model.sv
sim/pll_reconfig_ctrl_tb.sv

// ==== sim/pll_reconfig_ctrl_tb.sv ====
`timescale 1ns/10ps

module pll_reconfig_ctrl_tb;
  import pll_reconfig_pkg::*;

  // Entry 0 in the low field
  localparam logic [31:0] ROM_RC  = {7'h55, 5'd24, 5'd3, 5'd22, 5'd15, 5'd7};
  localparam logic [31:0] ROM_CGB = {12'hABC, 4'd7, 4'd2, 4'd12, 4'd9, 4'd6};
  localparam int          TIMEOUT = 400;  // Cycles per wait

  logic                   clk;
  logic                   reset;
  uif_req_t               uif;
  logic                   uif_busy;
  logic [UIF_DATA_W-1:0]  uif_rdata;
  logic                   uif_addr_err;
  ctrl_req_t              ctrl;
  logic                   ctrl_wait;
  logic [CTRL_DATA_W-1:0] ctrl_rdata;
  logic                   l2p_phase;     // ROM-only fetch running
  logic                   switch_phase;  // Full switch running
  logic [LCH_W-1:0]       lch_exp;       // Channel carried by each job
  int                     errors;
  int                     tests;
  int                     failed;
  int                     test_err0;

  pll_reconfig_ctrl dut0 (.*);

  basic_block_model #(.ROM_RC(ROM_RC), .ROM_CGB(ROM_CGB)) bb0 (
    .clk, .reset, .ctrl, .ctrl_wait, .ctrl_rdata);

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  a_l2p_unlocked: assert property (@(posedge clk) disable iff (reset) l2p_phase |-> !ctrl.lock)
    else begin
      $display("[ERROR] %0t ctrl.lock got 1 expected 0", $time);
      errors++;
    end
  a_switch_locked: assert property (@(posedge clk) disable iff (reset)
    switch_phase && uif_busy |-> ctrl.lock)
    else begin
      $display("[ERROR] %0t ctrl.lock got 0 expected 1", $time);
      errors++;
    end
  a_lch_passed: assert property (@(posedge clk) disable iff (reset)
    ctrl.go |-> ctrl.lch == lch_exp)
    else begin
      $display("[ERROR] %0t ctrl.lch got %h expected %h", $time, ctrl.lch, lch_exp);
      errors++;
    end

  ////////////////////////////////////////
  // Reference model of the remap rules
  ////////////////////////////////////////
  function automatic logic [9:0] cgb_code(input logic [3:0] id);
    case (id)  // {x_en, clk_sel}
      4'd1:    return 10'b00_0000_0011;
      4'd2:    return 10'b00_0101_0000;
      4'd3:    return 10'b00_1010_0000;
      4'd4:    return 10'b00_1111_0000;
      4'd5:    return 10'b00_0000_0010;
      4'd6:    return 10'b10_0001_1000;
      4'd7:    return 10'b01_0001_0100;
      4'd8:    return 10'b00_0001_0100;
      4'd9:    return 10'b00_0001_1000;
      default: return 10'b00_0101_1100;  // Same channel
    endcase
  endfunction

  function automatic logic [8:0] rc_code(input logic [4:0] id, input logic atx);
    if (id <= 5'd10) return {5'd0, 4'(id + 5'd1)};       // {rref, network}
    if (id <= 5'd21) return {1'b0, 4'(id - 5'd10), 4'h0};
    if (atx) return (id == 5'd22) ? 9'h00C : ((id == 5'd23) ? 9'h000 : 9'h001);
    case (id)
      5'd22:        return 9'h100;
      5'd23, 5'd25: return 9'h000;
      5'd24:        return 9'h00C;
      default:      return 9'h001;
    endcase
  endfunction

  function automatic logic [11:0] word_addr(input logic is_cgb, input logic atx, input int cnt);
    if (is_cgb) return OFST_CGB;
    case (cnt)
      2:       return atx ? OFST_ATX_RCMU : OFST_PCIEMD;
      1:       return atx ? OFST_ATX_CLK35 : OFST_RREF;
      default: return atx ? OFST_ATX_CLK36 : OFST_REFIQ;
    endcase
  endfunction

  function automatic logic [15:0] merge_word(input logic is_cgb, input logic atx, input int cnt,
                                             input logic [15:0] old, input logic [9:0] code);
    logic [15:0] w;
    w = old;
    if (is_cgb) begin
      w[15:14] = code[9:8];
      w[8:1]   = code[7:0];
    end else if (atx) begin
      case (cnt)
        2:       w[1:0]   = 2'b00;      // RCMU mux stays at zero
        1:       w[15:11] = code[4:0];
        default: w[2:0]   = code[7:5];
      endcase
    end else begin
      case (cnt)
        2:       w[6]    = 1'b0;        // PCIe mode off
        1:       w[15]   = code[8];
        default: w[10:3] = code[7:0];
      endcase
    end
    return w;
  endfunction

  task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp)
    else begin
      $display("[ERROR] %0t %s got %h expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic end_test(input string name);
    tests++;
    if (errors != test_err0) failed++;
    if (errors == test_err0) $display("Test %0d %s: ok", tests, name);
    else $display("Test %0d %s: %0d errors", tests, name, errors - test_err0);
    test_err0 = errors;
  endtask

  ////////////////////////////////////////
  // User port drivers
  ////////////////////////////////////////
  task automatic user_write(input logic [2:0] addr, input logic [31:0] data);
    @(posedge clk);
    uif.go    <= 1'b1;
    uif.mode  <= UIF_WR;
    uif.addr  <= addr;
    uif.wdata <= data;
    uif.lch   <= lch_exp;
    @(posedge clk);
    uif.go <= 1'b0;
  endtask

  task automatic user_read(input logic [2:0] addr, output logic [31:0] data);
    @(posedge clk);
    uif.go   <= 1'b1;
    uif.mode <= UIF_RD;
    uif.addr <= addr;
    uif.lch  <= lch_exp;
    @(posedge clk);
    uif.go <= 1'b0;
    @(negedge clk);  // Registered one cycle after the read
    data = uif_rdata;
    check_eq("uif_addr_err", uif_addr_err, addr > REG_PLL_TYPE);
  endtask

  task automatic timeout_fail(input string what);
    $display("Timeout: %s within %0d cycles", what, TIMEOUT);
    $display("TESTBENCH FAILED");
    $finish;
  endtask

  // Busy rise then fall marks one job
  task automatic wait_job();
    int n;
    n = 0;
    while (!uif_busy && n < TIMEOUT) begin
      @(negedge clk);
      n++;
    end
    if (!uif_busy) timeout_fail("uif_busy did not rise");
    n = 0;
    while (uif_busy && n < TIMEOUT) begin
      @(negedge clk);
      n++;
    end
    if (uif_busy) timeout_fail("uif_busy did not fall");
  endtask

  task automatic write_and_wait(input logic [2:0] addr, input logic [31:0] data);
    switch_phase = 1'b1;
    user_write(addr, data);
    wait_job();
    switch_phase = 1'b0;
  endtask

  task automatic run_switch(input logic is_cgb, input logic atx, input logic [2:0] idx);
    logic [15:0] prior [3];
    logic [9:0]  code;
    logic [46:0] acc;
    int          n_words;
    int          k;
    int          cnt;
    n_words = is_cgb ? 1 : 3;
    lch_exp = 10'h2A5 ^ LCH_W'({is_cgb, atx, idx});  // New channel per switch
    if (is_cgb) code = cgb_code((idx < 5) ? ROM_CGB[idx*4 +: 4] : ROM_CGB[3:0]);
    else code = {1'b0, rc_code((idx < 5) ? ROM_RC[idx*5 +: 5] : ROM_RC[4:0], atx)};
    for (k = 0; k < n_words; k++)
      prior[k] = bb0.mem[word_addr(is_cgb, atx, n_words - 1 - k)];
    bb0.log_q.delete();
    write_and_wait(is_cgb ? REG_CGB_SEL : REG_RC_SEL, 32'(idx));
    check_eq("access count", bb0.log_q.size(), 1 + 2 * n_words);
    if (bb0.log_q.size() == 1 + 2 * n_words) begin
      acc = bb0.log_q[0];
      check_eq("ctrl.opcode", acc[46:44], OP_ROM_RD);
      check_eq("ctrl.addr", acc[43:32], is_cgb ? WORD_SEL_CGB : WORD_SEL_RC);
      for (k = 0; k < n_words; k++) begin
        cnt = n_words - 1 - k;  // Counter runs down
        acc = bb0.log_q[1 + 2 * k];
        check_eq("ctrl.opcode", acc[46:44], (atx && !is_cgb) ? OP_PRD : OP_RD);
        check_eq("ctrl.addr", acc[43:32], word_addr(is_cgb, atx, cnt));
        acc = bb0.log_q[2 + 2 * k];
        check_eq("ctrl.opcode", acc[46:44], (atx && !is_cgb) ? OP_PWR : OP_WR);
        check_eq("ctrl.addr", acc[43:32], word_addr(is_cgb, atx, cnt));
        check_eq("ctrl.wdata", acc[31:0], {16'd0, merge_word(is_cgb, atx, cnt, prior[k], code)});
      end
    end
  endtask

  ////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////
  initial begin
    logic [31:0] rd;
    logic [46:0] acc;
    int          i;
    errors       = 0;
    tests        = 0;
    failed       = 0;
    test_err0    = 0;
    l2p_phase    = 1'b0;
    switch_phase = 1'b0;
    lch_exp      = '0;
    uif          = '0;
    reset        = 1'b1;
    repeat (8) @(posedge clk);
    reset <= 1'b0;

    for (i = 0; i < 4; i++) begin  // Quiet after reset
      @(negedge clk);
      check_eq("uif_busy", uif_busy, 0);
      check_eq("ctrl.go", ctrl.go, 0);
      check_eq("ctrl.lock", ctrl.lock, 0);
    end
    check_eq("ctrl.opcode", ctrl.opcode, OP_RD);
    check_eq("ctrl.addr", ctrl.addr, 0);
    check_eq("ctrl.wdata", ctrl.wdata, 0);
    for (i = 0; i < 5; i++) begin
      l2p_phase = (i == 2) || (i == 3);  // Map reads start a ROM fetch
      user_read(3'(i), rd);
      check_eq("uif_rdata", rd, 0);
      if (l2p_phase) wait_job();
      l2p_phase = 1'b0;
    end
    end_test("reset values");

    write_and_wait(REG_RC_SEL, 32'hFFFF_FFF5);
    write_and_wait(REG_CGB_SEL, 32'h0000_00AB);
    user_write(REG_PLL_TYPE, 32'h0000_0003);
    user_read(REG_RC_SEL, rd);
    check_eq("uif_rdata", rd, 32'd5);
    user_read(REG_CGB_SEL, rd);
    check_eq("uif_rdata", rd, 32'd3);
    user_read(REG_PLL_TYPE, rd);
    check_eq("uif_rdata", rd, 32'd1);
    for (i = 5; i < 8; i++) begin  // Unmapped offsets
      user_read(3'(i), rd);
      check_eq("uif_rdata", rd, 0);
    end
    user_write(REG_PLL_TYPE, 32'd0);
    end_test("register readback");

    bb0.log_q.delete();
    l2p_phase = 1'b1;
    lch_exp   = 10'h13C;
    user_read(REG_RC_MAP, rd);
    wait_job();
    check_eq("access count", bb0.log_q.size(), 1);
    if (bb0.log_q.size() == 1) begin
      acc = bb0.log_q[0];
      check_eq("ctrl.opcode", acc[46:44], OP_ROM_RD);
      check_eq("ctrl.addr", acc[43:32], WORD_SEL_RC);
    end
    user_read(REG_RC_MAP, rd);
    check_eq("uif_rdata", rd, {7'd0, ROM_RC[24:0]});
    wait_job();
    l2p_phase = 1'b0;
    end_test("ROM map fetch");

    run_switch(1'b1, 1'b0, 3'd0);
    end_test("CGB switch");
    run_switch(1'b0, 1'b0, 3'd2);
    end_test("CDR refclk switch");
    user_write(REG_PLL_TYPE, 32'd1);
    run_switch(1'b0, 1'b1, 3'd1);
    end_test("ATX refclk switch");

    $display("Tests run %0d, failed %0d, errors %0d", tests, failed, errors);
    if (errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

// ==== sim/basic_block_model.sv ====
`timescale 1ns/10ps

module basic_block_model #(
  parameter logic [31:0] ROM_RC  = '0,  // Refclk map word
  parameter logic [31:0] ROM_CGB = '0   // CGB map word
) (
  input  logic                                     clk,
  input  logic                                     reset,
  input  pll_reconfig_pkg::ctrl_req_t              ctrl,
  output logic                                     ctrl_wait,
  output logic [pll_reconfig_pkg::CTRL_DATA_W-1:0] ctrl_rdata
);
  import pll_reconfig_pkg::*;

  logic [15:0] mem [0:4095];  // DPRIO space
  logic [46:0] log_q [$];     // {opcode, addr, wdata} per access
  logic [1:0]  wait_left;     // Busy cycles still to go
  integer      seed;
  integer      i;

  initial begin
    seed = 32'ha6bb_faaf;
    for (i = 0; i < 4096; i++)
      mem[i] = 16'($random(seed));
  end

  // Read data follows the request fields
  always_comb begin
    case (ctrl.opcode)
      OP_ROM_RD:     ctrl_rdata = (ctrl.addr == WORD_SEL_CGB) ? ROM_CGB : ROM_RC;
      OP_RD, OP_PRD: ctrl_rdata = {16'd0, mem[ctrl.addr]};
      default:       ctrl_rdata = '0;
    endcase
  end

  ////////////////////////////////////////
  // Access capture and back-pressure
  ////////////////////////////////////////
  always @(posedge clk or posedge reset) begin
    if (reset) begin
      ctrl_wait <= 1'b0;
      wait_left <= '0;
    end else if (ctrl.go) begin
      ctrl_wait <= 1'b1;
      wait_left <= 2'($random(seed));  // 1 to 4 busy cycles
      log_q.push_back({ctrl.opcode, ctrl.addr, ctrl.wdata});
      if (ctrl.opcode inside {OP_WR, OP_PWR})
        mem[ctrl.addr] <= ctrl.wdata[15:0];
    end else if (wait_left != 2'd0) begin
      wait_left <= wait_left - 2'd1;
    end else begin
      ctrl_wait <= 1'b0;
    end
  end

endmodule

// ==== source/pll_reconfig_ctrl.sv ====
`timescale 1ns/10ps

module pll_reconfig_ctrl #(
  parameter int MAP_N = pll_reconfig_pkg::MAP_ENTRIES  // Logical entries per ROM word
) (
  input  logic                                     clk,
  input  logic                                     reset,
  input  pll_reconfig_pkg::uif_req_t               uif,
  output logic                                     uif_busy,
  output logic [pll_reconfig_pkg::UIF_DATA_W-1:0]  uif_rdata,
  output logic                                     uif_addr_err,
  output pll_reconfig_pkg::ctrl_req_t              ctrl,
  input  logic                                     ctrl_wait,
  input  logic [pll_reconfig_pkg::CTRL_DATA_W-1:0] ctrl_rdata
);
  import pll_reconfig_pkg::*;

  switch_cmd_t                  cmd;
  clk_sel_t                     sel;
  pll_state_e                   state;
  ctrl_op_e                     opcode;
  logic [1:0]                   word_cnt;
  logic                         go;
  logic                         lock;
  logic                         rom_rd_cycle;
  logic                         read_cycle;
  logic [MAP_N*REFCLK_ID_W-1:0] rc_map;
  logic [MAP_N*CGB_ID_W-1:0]    cgb_map;
  logic [CTRL_ADDR_W-1:0]       addr;
  logic [CTRL_DATA_W-1:0]       wdata;

  pll_user_regs #(.MAP_N(MAP_N)) regs0 (
    .clk, .reset, .uif, .busy(uif_busy), .rc_map, .cgb_map,
    .uif_rdata, .uif_addr_err, .cmd);

  pll_l2p_map #(.MAP_N(MAP_N)) map0 (
    .clk, .reset, .cmd, .ctrl_wait, .ctrl_rdata, .rom_rd_cycle,
    .rc_map, .cgb_map, .sel);

  pll_rmw_datapath dp0 (
    .clk, .reset, .cmd, .sel, .state, .word_cnt, .ctrl_wait, .read_cycle,
    .ctrl_rdata, .ctrl_addr(addr), .ctrl_wdata(wdata));

  pll_rmw_sequencer seq0 (
    .clk, .reset, .cmd, .ctrl_wait, .state, .word_cnt, .go, .lock, .opcode,
    .rom_rd_cycle, .read_cycle, .busy(uif_busy));

  // Channel passes straight from the user side
  assign ctrl = '{go: go, opcode: opcode, lock: lock, lch: uif.lch, addr: addr, wdata: wdata};

endmodule

// ==== source/pll_rmw_sequencer.sv ====
`timescale 1ns/10ps

module pll_rmw_sequencer (
  input  logic                          clk,
  input  logic                          reset,
  input  pll_reconfig_pkg::switch_cmd_t cmd,
  input  logic                          ctrl_wait,
  output pll_reconfig_pkg::pll_state_e  state,
  output logic [1:0]                    word_cnt,
  output logic                          go,
  output logic                          lock,
  output pll_reconfig_pkg::ctrl_op_e    opcode,
  output logic                          rom_rd_cycle,
  output logic                          read_cycle,
  output logic                          busy
);
  import pll_reconfig_pkg::*;

  pll_state_e next_state;
  logic [1:0] event_cnt;   // DECIDE entries within one word
  logic       l2p_active;  // ROM fetch without RMW
  logic       l2p_job;
  logic       atx_refclk;  // Physical addressing needed

  assign l2p_job    = (state == ST_IDLE) ? cmd.l2p_only : l2p_active;
  assign atx_refclk = cmd.is_atx && !cmd.is_cgb;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) state <= ST_IDLE;
    else       state <= next_state;
  end

  ////////////////////////////////////////
  // Next state
  ////////////////////////////////////////
  always_comb begin
    next_state = state;
    case (state)
      ST_IDLE:   if (cmd.start || cmd.l2p_only) next_state = ST_RD_L2P;
      ST_RD_L2P, ST_RD, ST_WR: next_state = ST_WAIT;  // One go each
      ST_WAIT:   next_state = ST_DECIDE;             // Let ctrl_wait rise
      ST_DECIDE: begin
        if (!ctrl_wait) begin
          if (l2p_active)           next_state = ST_IDLE;
          else if (event_cnt == 2'd1) next_state = ST_RD;
          else if (event_cnt == 2'd2) next_state = ST_WR;
          else                        next_state = ST_CHK_WORDS;
        end
      end
      ST_CHK_WORDS: next_state = (word_cnt == 2'd0) ? ST_IDLE : ST_WAIT;
      default:      next_state = ST_IDLE;
    endcase
  end

  // Event tracer and job flags
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      event_cnt  <= '0;
      l2p_active <= 1'b0;
      word_cnt   <= '0;
    end else begin
      if (state == ST_IDLE || (state == ST_DECIDE && next_state == ST_CHK_WORDS))
        event_cnt <= '0;
      else if (next_state == ST_DECIDE && state != ST_DECIDE)
        event_cnt <= event_cnt + 2'd1;
      if (state == ST_DECIDE && next_state == ST_IDLE)
        l2p_active <= 1'b0;
      else if (state == ST_IDLE && cmd.l2p_only)
        l2p_active <= 1'b1;
      // Three words for refclk, one for CGB
      if (state == ST_RD_L2P)
        word_cnt <= cmd.is_cgb ? 2'd0 : 2'd2;
      else if (state == ST_CHK_WORDS && next_state == ST_WAIT)
        word_cnt <= word_cnt - 2'd1;
    end
  end

  ////////////////////////////////////////
  // Control strobes
  ////////////////////////////////////////
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      busy   <= 1'b0;
      go     <= 1'b0;
      lock   <= 1'b0;
      opcode <= OP_RD;
    end else begin
      busy <= next_state != ST_IDLE;
      go   <= (state == ST_RD_L2P) || (state == ST_RD) || (state == ST_WR);
      lock <= (next_state != ST_IDLE) && !l2p_job;  // Spans the whole switch
      if (next_state == ST_IDLE)
        opcode <= OP_RD;
      else if (state == ST_RD_L2P)
        opcode <= OP_ROM_RD;
      else if (state == ST_RD)
        opcode <= atx_refclk ? OP_PRD : OP_RD;
      else if (state == ST_WR)
        opcode <= atx_refclk ? OP_PWR : OP_WR;
    end
  end

  // Completion qualifiers for the read data path
  assign rom_rd_cycle = (state == ST_DECIDE) && (opcode == OP_ROM_RD);
  assign read_cycle   = (state == ST_DECIDE) && ((opcode == OP_RD) || (opcode == OP_PRD));

  a_go_single: assert property (@(posedge clk) disable iff (reset) go |=> !go);
  a_state_legal: assert property (@(posedge clk) disable iff (reset)
    state inside {ST_IDLE, ST_RD_L2P, ST_WAIT, ST_DECIDE, ST_RD, ST_WR, ST_CHK_WORDS});

endmodule

// ==== source/pll_rmw_datapath.sv ====
`timescale 1ns/10ps

module pll_rmw_datapath (
  input  logic                                    clk,
  input  logic                                    reset,
  input  pll_reconfig_pkg::switch_cmd_t           cmd,
  input  pll_reconfig_pkg::clk_sel_t              sel,
  input  pll_reconfig_pkg::pll_state_e            state,
  input  logic [1:0]                              word_cnt,
  input  logic                                    ctrl_wait,
  input  logic                                    read_cycle,
  input  logic [pll_reconfig_pkg::CTRL_DATA_W-1:0] ctrl_rdata,
  output logic [pll_reconfig_pkg::CTRL_ADDR_W-1:0] ctrl_addr,
  output logic [pll_reconfig_pkg::CTRL_DATA_W-1:0] ctrl_wdata
);
  import pll_reconfig_pkg::*;

  logic [15:0]            saved;    // DPRIO word from the last read
  logic [15:0]            merged;
  logic [CTRL_ADDR_W-1:0] dprio_addr;

  always_ff @(posedge clk) begin
    if (read_cycle && !ctrl_wait)
      saved <= ctrl_rdata[15:0];
  end

  ////////////////////////////////////////
  // Field merge and DPRIO offset
  ////////////////////////////////////////
  always_comb begin
    if (cmd.is_cgb) begin
      merged     = {sel.cgb_x_en, saved[13:9], sel.cgb_clk_sel, saved[0]};
      dprio_addr = OFST_CGB;  // Single word switch
    end else if (cmd.is_atx) begin
      case (word_cnt)
        2'd2: begin
          merged     = {saved[15:2], sel.rcmu_mux_sel};         // Back end mux
          dprio_addr = OFST_ATX_RCMU;
        end
        2'd1: begin
          merged     = {sel.clk_network[4:0], saved[10:0]};     // Front end, low part
          dprio_addr = OFST_ATX_CLK35;
        end
        default: begin
          merged     = {saved[15:3], sel.clk_network[7:5]};     // Front end, high part
          dprio_addr = OFST_ATX_CLK36;
        end
      endcase
    end else begin
      case (word_cnt)
        2'd2: begin
          merged     = {saved[15:7], sel.pcie_mode, saved[5:0]};
          dprio_addr = OFST_PCIEMD;
        end
        2'd1: begin
          merged     = {sel.rrefclk_sel, saved[14:0]};
          dprio_addr = OFST_RREF;
        end
        default: begin
          merged     = {saved[15:11], sel.iq_clk_sel, saved[2:0]};
          dprio_addr = OFST_REFIQ;
        end
      endcase
    end
  end

  // Address and write data, aligned with the go strobe
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      ctrl_addr  <= '0;
      ctrl_wdata <= '0;
    end else begin
      case (state)
        ST_IDLE: begin
          ctrl_addr  <= '0;
          ctrl_wdata <= '0;
        end
        ST_RD_L2P: ctrl_addr <= cmd.is_cgb ? WORD_SEL_CGB : WORD_SEL_RC;
        ST_RD:     ctrl_addr <= dprio_addr;
        ST_WR: begin
          ctrl_addr  <= dprio_addr;
          ctrl_wdata <= {16'd0, merged};  // Upper half unused
        end
        default: ;
      endcase
    end
  end

endmodule

// ==== source/pll_l2p_map.sv ====
`timescale 1ns/10ps

module pll_l2p_map #(
  parameter int MAP_N = pll_reconfig_pkg::MAP_ENTRIES
) (
  input  logic                                           clk,
  input  logic                                           reset,
  input  pll_reconfig_pkg::switch_cmd_t                  cmd,
  input  logic                                           ctrl_wait,
  input  logic [pll_reconfig_pkg::CTRL_DATA_W-1:0]       ctrl_rdata,
  input  logic                                           rom_rd_cycle,
  output logic [MAP_N*pll_reconfig_pkg::REFCLK_ID_W-1:0] rc_map,
  output logic [MAP_N*pll_reconfig_pkg::CGB_ID_W-1:0]    cgb_map,
  output pll_reconfig_pkg::clk_sel_t                     sel
);
  import pll_reconfig_pkg::*;

  logic [REFCLK_ID_W-1:0] rc_id;
  logic [CGB_ID_W-1:0]    cgb_id;
  logic [10:0]            cgb_code;   // x_en, clknet_in_en, clk_sel
  logic [7:0]             net_code;   // Refclk mux code, CDR or ATX
  logic                   rref;

  // ROM word capture, one map per job type
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      rc_map  <= '0;
      cgb_map <= '0;
    end else if (rom_rd_cycle && !ctrl_wait) begin
      if (cmd.is_cgb)
        cgb_map <= ctrl_rdata[MAP_N*CGB_ID_W-1:0];
      else
        rc_map  <= ctrl_rdata[MAP_N*REFCLK_ID_W-1:0];
    end
  end

  // Logical index into the stored map
  always_comb begin
    if (cmd.index < MAP_N) begin
      rc_id  = rc_map[cmd.index*REFCLK_ID_W +: REFCLK_ID_W];
      cgb_id = cgb_map[cmd.index*CGB_ID_W +: CGB_ID_W];
    end else begin
      rc_id  = rc_map[REFCLK_ID_W-1:0];  // Out of range, entry 0
      cgb_id = cgb_map[CGB_ID_W-1:0];
    end
  end

  ////////////////////////////////////////
  // CGB remap
  ////////////////////////////////////////
  always_comb begin
    case (cgb_id)
      4'd1:    cgb_code = {2'b00, 1'b0, 8'b0000_0011};  // x1 top
      4'd2:    cgb_code = {2'b00, 1'b0, 8'b0101_0000};  // x1 bottom
      4'd3:    cgb_code = {2'b00, 1'b0, 8'b1010_0000};  // LC top
      4'd4:    cgb_code = {2'b00, 1'b0, 8'b1111_0000};  // LC bottom
      4'd5:    cgb_code = {2'b00, 1'b0, 8'b0000_0010};  // fPLL
      4'd6:    cgb_code = {2'b10, 1'b1, 8'b0001_1000};  // x6 up
      4'd7:    cgb_code = {2'b01, 1'b1, 8'b0001_0100};  // x6 down
      4'd8:    cgb_code = {2'b00, 1'b1, 8'b0001_0100};  // xN up
      4'd9:    cgb_code = {2'b00, 1'b1, 8'b0001_1000};  // xN down
      default: cgb_code = {2'b00, 1'b0, 8'b0101_1100};  // Same channel TX PLL
    endcase
  end

  ////////////////////////////////////////
  // Refclk remap
  ////////////////////////////////////////
  always_comb begin
    net_code = 8'h01;  // Refclk IQ0 by default
    rref     = 1'b0;
    if (rc_id <= 5'd10) begin
      net_code = {4'h0, 4'(rc_id + 5'd1)};       // Ref IQ clocks
    end else if (rc_id <= 5'd21) begin
      net_code = {4'(rc_id - 5'd10), 4'h0};      // RX IQ clocks
    end else if (cmd.is_atx) begin
      case (rc_id)
        5'd22:   net_code = 8'h0C;  // fPLL top
        5'd23:   net_code = 8'h00;  // fPLL bottom
        default: net_code = 8'h01;
      endcase
    end else begin
      case (rc_id)
        5'd22: begin
          rref     = 1'b1;          // PLD clock
          net_code = 8'h00;
        end
        5'd23, 5'd25: net_code = 8'h00;  // Cal clock, fPLL bottom
        5'd24:        net_code = 8'h0C;  // fPLL top
        default:      net_code = 8'h01;
      endcase
    end
  end

  assign sel = '{cgb_x_en:     cgb_code[10:9],
                 clknet_in_en: cgb_code[8],
                 cgb_clk_sel:  cgb_code[7:0],
                 rrefclk_sel:  rref,
                 pcie_mode:    1'b0,
                 iq_clk_sel:   net_code,
                 rcmu_mux_sel: 2'b00,
                 clk_network:  net_code};

  // Job type holds from the ROM address cycle to the capture
  a_map_type_held: assert property (@(posedge clk) disable iff (reset)
    rom_rd_cycle |-> $stable(cmd.is_cgb) && (cmd.is_cgb == $past(cmd.is_cgb, 2)));

endmodule

// ==== source/pll_user_regs.sv ====
`timescale 1ns/10ps

module pll_user_regs #(
  parameter int MAP_N = pll_reconfig_pkg::MAP_ENTRIES
) (
  input  logic                                       clk,
  input  logic                                       reset,
  input  pll_reconfig_pkg::uif_req_t                 uif,
  input  logic                                       busy,
  input  logic [MAP_N*pll_reconfig_pkg::REFCLK_ID_W-1:0] rc_map,
  input  logic [MAP_N*pll_reconfig_pkg::CGB_ID_W-1:0]    cgb_map,
  output logic [pll_reconfig_pkg::UIF_DATA_W-1:0]    uif_rdata,
  output logic                                       uif_addr_err,
  output pll_reconfig_pkg::switch_cmd_t              cmd
);
  import pll_reconfig_pkg::*;

  logic       wr;
  logic       rd;
  logic       sel_wr;     // Offset 0 or 1 written
  logic       map_rd;     // Offset 2 or 3 read
  logic [2:0] rc_sel;
  logic [2:0] cgb_sel;
  logic       pll_type;   // 1 means ATX
  logic       start;
  logic       l2p_only;
  logic       is_cgb;

  assign wr     = uif.go && (uif.mode == UIF_WR);
  assign rd     = uif.go && (uif.mode == UIF_RD);
  assign sel_wr = wr && ((uif.addr == REG_RC_SEL) || (uif.addr == REG_CGB_SEL));
  assign map_rd = rd && ((uif.addr == REG_RC_MAP) || (uif.addr == REG_CGB_MAP));

  // Selection registers, written even while busy
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      rc_sel   <= '0;
      cgb_sel  <= '0;
      pll_type <= 1'b0;
    end else if (wr) begin
      if (uif.addr == REG_RC_SEL)   rc_sel   <= uif.wdata[2:0];
      if (uif.addr == REG_CGB_SEL)  cgb_sel  <= uif.wdata[2:0];
      if (uif.addr == REG_PLL_TYPE) pll_type <= uif.wdata[0];
    end
  end

  // Job strobes and type, held off while a job runs
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      start    <= 1'b0;
      l2p_only <= 1'b0;
      is_cgb   <= 1'b0;
    end else begin
      start    <= sel_wr && !busy;
      l2p_only <= map_rd && !busy;
      if (!busy && (sel_wr || map_rd))
        is_cgb <= (uif.addr == REG_CGB_SEL) || (uif.addr == REG_CGB_MAP);
    end
  end

  assign cmd = '{start: start, l2p_only: l2p_only, is_cgb: is_cgb, is_atx: pll_type,
                 index: is_cgb ? cgb_sel : rc_sel};

  // Readback, right aligned
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      uif_rdata    <= '0;
      uif_addr_err <= 1'b0;
    end else begin
      uif_addr_err <= uif.addr > REG_PLL_TYPE;
      if (uif.mode == UIF_RD) begin
        case (uif.addr)
          REG_RC_SEL:   uif_rdata <= UIF_DATA_W'(rc_sel);
          REG_CGB_SEL:  uif_rdata <= UIF_DATA_W'(cgb_sel);
          REG_RC_MAP:   uif_rdata <= UIF_DATA_W'(rc_map);   // Last ROM fetch
          REG_CGB_MAP:  uif_rdata <= UIF_DATA_W'(cgb_map);
          REG_PLL_TYPE: uif_rdata <= UIF_DATA_W'(pll_type);
          default:      uif_rdata <= '0;
        endcase
      end
    end
  end

endmodule

// ==== source/pll_reconfig_pkg.sv ====
package pll_reconfig_pkg;

  ////////////////////////////////////////
  // Widths
  ////////////////////////////////////////
  localparam int UIF_ADDR_W  = 3;   // User register offset
  localparam int UIF_DATA_W  = 32;
  localparam int CTRL_ADDR_W = 12;  // Basic block address
  localparam int CTRL_DATA_W = 32;
  localparam int LCH_W       = 10;  // Logical channel
  localparam int REFCLK_ID_W = 5;   // One physical refclk id
  localparam int CGB_ID_W    = 4;   // One physical CGB id
  localparam int MAP_ENTRIES = 5;   // Logical entries per ROM word

  // User operations
  typedef enum logic {
    UIF_RD = 1'b0,
    UIF_WR = 1'b1
  } uif_mode_e;

  // Basic block opcodes
  typedef enum logic [2:0] {
    OP_RD     = 3'd0,
    OP_WR     = 3'd1,
    OP_ROM_RD = 3'd4,  // Logical to physical ROM
    OP_PRD    = 3'd5,  // Physical addressing read
    OP_PWR    = 3'd6   // Physical addressing write
  } ctrl_op_e;

  // Sequencer states
  typedef enum logic [2:0] {
    ST_IDLE, ST_RD_L2P, ST_WAIT, ST_DECIDE, ST_RD, ST_WR, ST_CHK_WORDS
  } pll_state_e;

  // User register offsets
  localparam logic [UIF_ADDR_W-1:0] REG_RC_SEL   = 3'd0;
  localparam logic [UIF_ADDR_W-1:0] REG_CGB_SEL  = 3'd1;
  localparam logic [UIF_ADDR_W-1:0] REG_RC_MAP   = 3'd2;  // Read only
  localparam logic [UIF_ADDR_W-1:0] REG_CGB_MAP  = 3'd3;  // Read only
  localparam logic [UIF_ADDR_W-1:0] REG_PLL_TYPE = 3'd4;  // 0 CDR, 1 ATX

  // ROM word selects
  localparam logic [CTRL_ADDR_W-1:0] WORD_SEL_RC  = 12'd1;
  localparam logic [CTRL_ADDR_W-1:0] WORD_SEL_CGB = 12'd2;

  ////////////////////////////////////////
  // DPRIO offsets
  ////////////////////////////////////////
  localparam logic [CTRL_ADDR_W-1:0] OFST_CGB       = 12'h013;
  localparam logic [CTRL_ADDR_W-1:0] OFST_CLKNET    = 12'h014;  // Clock network enable word
  localparam logic [CTRL_ADDR_W-1:0] OFST_REFIQ     = 12'h03A;  // CDR, count 0
  localparam logic [CTRL_ADDR_W-1:0] OFST_RREF      = 12'h017;  // CDR, count 1
  localparam logic [CTRL_ADDR_W-1:0] OFST_PCIEMD    = 12'h010;  // CDR, count 2
  localparam logic [CTRL_ADDR_W-1:0] OFST_ATX_CLK36 = 12'h294;  // ATX, count 0
  localparam logic [CTRL_ADDR_W-1:0] OFST_ATX_CLK35 = 12'h293;  // ATX, count 1
  localparam logic [CTRL_ADDR_W-1:0] OFST_ATX_RCMU  = 12'h299;  // ATX, count 2

  typedef struct packed {
    logic                  go;
    uif_mode_e             mode;
    logic [UIF_ADDR_W-1:0] addr;
    logic [UIF_DATA_W-1:0] wdata;
    logic [LCH_W-1:0]      lch;
  } uif_req_t;

  typedef struct packed {
    logic                   go;      // One cycle strobe
    ctrl_op_e               opcode;
    logic                   lock;    // Held across a whole switch
    logic [LCH_W-1:0]       lch;
    logic [CTRL_ADDR_W-1:0] addr;
    logic [CTRL_DATA_W-1:0] wdata;
  } ctrl_req_t;

  typedef struct packed {
    logic       start;     // Full switch
    logic       l2p_only;  // ROM fetch only
    logic       is_cgb;
    logic       is_atx;
    logic [2:0] index;     // Logical selection
  } switch_cmd_t;

  typedef struct packed {
    logic [1:0] cgb_x_en;
    logic       clknet_in_en;
    logic [7:0] cgb_clk_sel;
    logic       rrefclk_sel;
    logic       pcie_mode;
    logic [7:0] iq_clk_sel;    // CDR refclk mux
    logic [1:0] rcmu_mux_sel;  // ATX back end mux
    logic [7:0] clk_network;   // ATX front end mux
  } clk_sel_t;

endpackage
